//--- hdl/rename_params.svh
// two-wide group only; register counts must keep the free list a power of two deep
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// ========================================
// group and register file sizes
// ========================================
`define RN_LANES      2
`define RN_ARCH_REGS  32
`define RN_PHYS_REGS  64

// field widths
`define RN_AREG_W     5
`define RN_PREG_W     6
`define RN_ECODE_W    6
`define RN_PLV_W      2

// ========================================
// exception codes
// ========================================
`define RN_ECODE_SYS  6'h0B
`define RN_ECODE_BRK  6'h0C
`define RN_ECODE_INE  6'h0D
`define RN_ECODE_IPE  6'h0E

// user mode privilege level
`define RN_PLV_USER   2'd3

`endif

//--- hdl/rename_pkg.sv
// shared rename types; field widths follow rename_params.svh and lane count is fixed at two
`default_nettype none

`include "rename_params.svh"

package rename_pkg;

  // ========================================
  // plain vectors
  // ========================================
  typedef logic [`RN_AREG_W-1:0]  areg_t;
  typedef logic [`RN_PREG_W-1:0]  preg_t;
  typedef logic [`RN_ECODE_W-1:0] ecode_t;
  typedef logic [`RN_PLV_W-1:0]   plv_t;

  typedef enum logic [2:0] {
    CLASS_ALU,
    CLASS_MEM,
    CLASS_BRANCH,
    CLASS_PRIV,
    CLASS_SYSCALL,
    CLASS_BRK
  } instr_class_e;

  // ========================================
  // decoded input
  // ========================================
  typedef struct packed {
    logic         valid;
    instr_class_e iclass;
    logic         invalid_inst;
    logic         fault_valid;
    ecode_t       fault_ecode;
    areg_t        src0;
    areg_t        src1;
    areg_t        dest;
  } dec_lane_t;

  typedef dec_lane_t [`RN_LANES-1:0] dec_group_t;

  // per-lane screening result
  typedef struct packed {
    logic   excp_valid;
    ecode_t ecode;
    logic   need_preg;
  } screen_t;

  typedef screen_t [`RN_LANES-1:0] screen_lanes_t;

  // one preg per lane, used for pops, frees and table results
  typedef preg_t [`RN_LANES-1:0] preg_lanes_t;

  // translated sources of one lane
  typedef struct packed {
    preg_t src0;
    preg_t src1;
  } psrc_t;

  typedef psrc_t [`RN_LANES-1:0] psrc_lanes_t;

  // ========================================
  // renamed output
  // ========================================
  typedef struct packed {
    logic   valid;
    logic   excp_valid;
    ecode_t ecode;
    logic   dest_valid;
    areg_t  arch_dest;
    preg_t  psrc0;
    preg_t  psrc1;
    preg_t  pdest;
    preg_t  old_pdest;
  } ren_lane_t;

  typedef ren_lane_t [`RN_LANES-1:0] ren_group_t;

endpackage

`default_nettype wire

//--- hdl/decode_screen.sv
// combinational; exception lanes are screened independently, invalid lanes never report
`default_nettype none

`include "rename_params.svh"

module decode_screen (
  input  rename_pkg::dec_group_t    dec_group_i,
  input  rename_pkg::plv_t          plv_i,
  output rename_pkg::screen_lanes_t screen_o
);

  logic user_mode;

  assign user_mode = (plv_i == `RN_PLV_USER);

  always_comb begin
    for (int i = 0; i < `RN_LANES; i++) begin
      screen_o[i].excp_valid = 1'b0;
      screen_o[i].ecode      = '0;

      // fixed priority, fetch fault first
      if (dec_group_i[i].fault_valid) begin
        screen_o[i].excp_valid = 1'b1;
        screen_o[i].ecode      = dec_group_i[i].fault_ecode;
      end else if (dec_group_i[i].invalid_inst) begin
        screen_o[i].excp_valid = 1'b1;
        screen_o[i].ecode      = `RN_ECODE_INE;
      end else if (dec_group_i[i].iclass == rename_pkg::CLASS_PRIV && user_mode) begin
        screen_o[i].excp_valid = 1'b1;
        screen_o[i].ecode      = `RN_ECODE_IPE;
      end else if (dec_group_i[i].iclass == rename_pkg::CLASS_SYSCALL) begin
        screen_o[i].excp_valid = 1'b1;
        screen_o[i].ecode      = `RN_ECODE_SYS;
      end else if (dec_group_i[i].iclass == rename_pkg::CLASS_BRK) begin
        screen_o[i].excp_valid = 1'b1;
        screen_o[i].ecode      = `RN_ECODE_BRK;
      end

      // empty lanes carry no exception
      if (!dec_group_i[i].valid) begin
        screen_o[i].excp_valid = 1'b0;
        screen_o[i].ecode      = '0;
      end

      // r0 writes are dropped, so no register
      screen_o[i].need_preg = dec_group_i[i].valid &&
                              !screen_o[i].excp_valid &&
                              (dec_group_i[i].dest != '0);
    end
  end

endmodule

`default_nettype wire

//--- hdl/free_list.sv
// no overflow check on commit frees; avail_o saturates at two and ignores same-cycle pushes
`default_nettype none

`include "rename_params.svh"

module free_list (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire [`RN_LANES-1:0]          pop_i,
  input  wire [`RN_LANES-1:0]          free_valid_i,
  input  rename_pkg::preg_lanes_t      free_preg_i,
  output rename_pkg::preg_lanes_t      head_o,
  output logic [1:0]                   avail_o
);

  localparam int FL_DEPTH = `RN_PHYS_REGS - `RN_ARCH_REGS;
  localparam int PTR_W    = $clog2(FL_DEPTH);
  localparam int CNT_W    = PTR_W + 1;

  rename_pkg::preg_t mem_q [FL_DEPTH];

  logic [PTR_W-1:0] head_q;
  logic [PTR_W-1:0] tail_q;
  logic [CNT_W-1:0] count_q;

  logic [1:0] pop_cnt;
  logic [1:0] push_cnt;
  logic [PTR_W-1:0] head_nxt1;
  logic [PTR_W-1:0] tail_lane1;

  // ========================================
  // head entries and occupancy
  // ========================================
  assign pop_cnt  = {1'b0, pop_i[0]} + {1'b0, pop_i[1]};
  assign push_cnt = {1'b0, free_valid_i[0]} + {1'b0, free_valid_i[1]};

  assign head_nxt1 = head_q + PTR_W'(1);

  // lane 1 alone takes the head entry
  assign head_o[0] = mem_q[head_q];
  assign head_o[1] = pop_i[0] ? mem_q[head_nxt1] : mem_q[head_q];

  assign avail_o = (count_q >= CNT_W'(2)) ? 2'd2 : count_q[1:0];

  // lane 1 free lands behind lane 0 only if lane 0 pushed
  assign tail_lane1 = tail_q + PTR_W'(free_valid_i[0]);

  // ========================================
  // storage and pointers
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // starts full with the registers above the identity map
      for (int i = 0; i < FL_DEPTH; i++) begin
        mem_q[i] <= rename_pkg::preg_t'(`RN_ARCH_REGS + i);
      end
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= CNT_W'(FL_DEPTH);
    end else begin
      if (free_valid_i[0]) begin
        mem_q[tail_q] <= free_preg_i[0];
      end
      if (free_valid_i[1]) begin
        mem_q[tail_lane1] <= free_preg_i[1];
      end
      head_q  <= head_q + PTR_W'(pop_cnt);
      tail_q  <= tail_q + PTR_W'(push_cnt);
      count_q <= count_q + CNT_W'(push_cnt) - CNT_W'(pop_cnt);
    end
  end

endmodule

`default_nettype wire

//--- hdl/rename_table.sv
// speculative map only, no checkpoint or recovery; r0 always maps to p0
`default_nettype none

`include "rename_params.svh"

module rename_table (
  input  wire                          clk,
  input  wire                          rst_n,
  input  rename_pkg::dec_group_t       lookup_i,
  input  wire [`RN_LANES-1:0]          alloc_i,
  input  rename_pkg::preg_lanes_t      new_preg_i,
  output rename_pkg::psrc_lanes_t      psrc_o,
  output rename_pkg::preg_lanes_t      pdest_o,
  output rename_pkg::preg_lanes_t      old_pdest_o
);

  rename_pkg::preg_t map_q [`RN_ARCH_REGS];

  // ========================================
  // lookup with bypass inside the group
  // ========================================
  always_comb begin
    for (int i = 0; i < `RN_LANES; i++) begin
      psrc_o[i].src0 = map_q[lookup_i[i].src0];
      psrc_o[i].src1 = map_q[lookup_i[i].src1];
      old_pdest_o[i] = map_q[lookup_i[i].dest];
      pdest_o[i]     = new_preg_i[i];

      // older lanes in the group override the table, youngest last
      for (int j = 0; j < i; j++) begin
        if (alloc_i[j] && lookup_i[j].dest == lookup_i[i].src0) begin
          psrc_o[i].src0 = new_preg_i[j];
        end
        if (alloc_i[j] && lookup_i[j].dest == lookup_i[i].src1) begin
          psrc_o[i].src1 = new_preg_i[j];
        end
        if (alloc_i[j] && lookup_i[j].dest == lookup_i[i].dest) begin
          old_pdest_o[i] = new_preg_i[j];
        end
      end
    end
  end

  // ========================================
  // update on accept
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < `RN_ARCH_REGS; r++) begin
        map_q[r] <= rename_pkg::preg_t'(r);
      end
    end else begin
      // ascending lane order, so lane 1 wins a shared dest
      for (int i = 0; i < `RN_LANES; i++) begin
        if (alloc_i[i] && lookup_i[i].dest != '0) begin
          map_q[lookup_i[i].dest] <= new_preg_i[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/rename_merge.sv
// single output register; a group is taken whole or stalled whole
`default_nettype none

`include "rename_params.svh"

module rename_merge (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          dec_valid_i,
  input  rename_pkg::dec_group_t       dec_group_i,
  input  rename_pkg::screen_lanes_t    screen_i,
  input  wire [1:0]                    avail_i,
  input  rename_pkg::psrc_lanes_t      psrc_i,
  input  rename_pkg::preg_lanes_t      pdest_i,
  input  rename_pkg::preg_lanes_t      old_pdest_i,
  input  wire                          ren_ready_i,
  output logic                         accept_o,
  output logic                         dec_ready_o,
  output logic                         ren_valid_o,
  output rename_pkg::ren_group_t       ren_group_o
);

  logic [1:0] need_cnt;
  logic       out_free;
  logic       fl_ok;

  rename_pkg::ren_group_t group_d;

  // ========================================
  // accept decision
  // ========================================
  assign need_cnt = {1'b0, screen_i[0].need_preg} + {1'b0, screen_i[1].need_preg};
  assign out_free = !ren_valid_o || ren_ready_i;
  assign fl_ok    = (avail_i >= need_cnt);

  assign dec_ready_o = out_free && fl_ok;
  assign accept_o    = dec_valid_i && dec_ready_o;

  // build renamed lanes
  always_comb begin
    for (int i = 0; i < `RN_LANES; i++) begin
      group_d[i].valid      = dec_group_i[i].valid;
      group_d[i].excp_valid = screen_i[i].excp_valid;
      group_d[i].ecode      = screen_i[i].ecode;
      group_d[i].dest_valid = screen_i[i].need_preg;
      group_d[i].arch_dest  = dec_group_i[i].dest;
      group_d[i].psrc0      = psrc_i[i].src0;
      group_d[i].psrc1      = psrc_i[i].src1;
      // no allocation means nothing to free at commit
      group_d[i].pdest      = screen_i[i].need_preg ? pdest_i[i] : '0;
      group_d[i].old_pdest  = screen_i[i].need_preg ? old_pdest_i[i] : '0;
    end
  end

  // ========================================
  // output register
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ren_valid_o <= 1'b0;
    end else if (accept_o) begin
      ren_valid_o <= 1'b1;
    end else if (ren_ready_i) begin
      ren_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept_o) begin
      ren_group_o <= group_d;
    end
  end

endmodule

`default_nettype wire

//--- hdl/rename_stage.sv
// rename top; no flush or recovery, commit frees must name registers previously allocated
`default_nettype none

`include "rename_params.svh"

module rename_stage (
  input  wire                          clk,
  input  wire                          rst_n,
  // decode side
  input  wire                          dec_valid_i,
  input  rename_pkg::dec_group_t       dec_group_i,
  input  rename_pkg::plv_t             plv_i,
  output logic                         dec_ready_o,
  // dispatch side
  output logic                         ren_valid_o,
  output rename_pkg::ren_group_t       ren_group_o,
  input  wire                          ren_ready_i,
  // commit frees
  input  wire [`RN_LANES-1:0]          free_valid_i,
  input  rename_pkg::preg_lanes_t      free_preg_i
);

  rename_pkg::screen_lanes_t screen;
  rename_pkg::preg_lanes_t   fl_head;
  rename_pkg::psrc_lanes_t   rat_psrc;
  rename_pkg::preg_lanes_t   rat_pdest;
  rename_pkg::preg_lanes_t   rat_old_pdest;

  logic [1:0]           fl_avail;
  logic                 accept;
  logic [`RN_LANES-1:0] fl_pop;

  // pop only for lanes that allocate on an accepting edge
  always_comb begin
    for (int i = 0; i < `RN_LANES; i++) begin
      fl_pop[i] = screen[i].need_preg && accept;
    end
  end

  // ========================================
  // instances
  // ========================================
  decode_screen u_screen (
    .dec_group_i (dec_group_i),
    .plv_i       (plv_i),
    .screen_o    (screen)
  );

  free_list u_free_list (
    .clk          (clk),
    .rst_n        (rst_n),
    .pop_i        (fl_pop),
    .free_valid_i (free_valid_i),
    .free_preg_i  (free_preg_i),
    .head_o       (fl_head),
    .avail_o      (fl_avail)
  );

  rename_table u_table (
    .clk         (clk),
    .rst_n       (rst_n),
    .lookup_i    (dec_group_i),
    .alloc_i     (fl_pop),
    .new_preg_i  (fl_head),
    .psrc_o      (rat_psrc),
    .pdest_o     (rat_pdest),
    .old_pdest_o (rat_old_pdest)
  );

  rename_merge u_merge (
    .clk         (clk),
    .rst_n       (rst_n),
    .dec_valid_i (dec_valid_i),
    .dec_group_i (dec_group_i),
    .screen_i    (screen),
    .avail_i     (fl_avail),
    .psrc_i      (rat_psrc),
    .pdest_i     (rat_pdest),
    .old_pdest_i (rat_old_pdest),
    .ren_ready_i (ren_ready_i),
    .accept_o    (accept),
    .dec_ready_o (dec_ready_o),
    .ren_valid_o (ren_valid_o),
    .ren_group_o (ren_group_o)
  );

endmodule

`default_nettype wire

//--- verif/rename_props.sv
// watches the rename output register only; payload is checked while valid since it has no reset
`default_nettype none

module rename_props (
  input wire                    clk,
  input wire                    rst_n,
  input wire                    valid_i,
  input wire                    ready_i,
  input rename_pkg::ren_group_t group_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // ========================================
  // output handshake
  // ========================================
  reset_idle: assert property (@(posedge clk) !rst_n |-> !valid_i)
    else $error("ren_valid_o high while reset is held");

  // stalled output keeps valid and payload
  hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    valid_i && !ready_i |=> valid_i && $stable(group_i))
    else $error("ren output changed while stalled");

  // an allocated dest never maps to p0
  lane0_pdest: assert property (@(posedge clk) disable iff (!rst_n)
    valid_i && group_i[0].valid && group_i[0].dest_valid |-> group_i[0].pdest != '0)
    else $error("lane 0 pdest is zero with dest_valid set");

  lane1_pdest: assert property (@(posedge clk) disable iff (!rst_n)
    valid_i && group_i[1].valid && group_i[1].dest_valid |-> group_i[1].pdest != '0)
    else $error("lane 1 pdest is zero with dest_valid set");

endmodule

bind rename_merge rename_props u_props (
  .clk     (clk),
  .rst_n   (rst_n),
  .valid_i (ren_valid_o),
  .ready_i (ren_ready_i),
  .group_i (ren_group_o)
);

`default_nettype wire

//--- verif/rename_tb.sv
// one group checked at a time on each side; commit frees reuse retired old mappings in order
`default_nettype none

`include "rename_params.svh"

module rename_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NROWS       = 60;
  localparam int STALL_LIMIT = 40;

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic                      dec_valid_i;
  rename_pkg::dec_group_t    dec_group_i;
  rename_pkg::plv_t          plv_i;
  logic                      dec_ready_o;
  logic                      ren_valid_o;
  rename_pkg::ren_group_t    ren_group_o;
  logic                      ren_ready_i;
  logic [`RN_LANES-1:0]      free_valid_i;
  rename_pkg::preg_lanes_t   free_preg_i;

  // stimulus table
  string                     row_name  [NROWS];
  rename_pkg::dec_group_t    row_grp   [NROWS];
  rename_pkg::plv_t          row_plv   [NROWS];
  int                        row_nfree [NROWS];
  int                        row_hold  [NROWS];

  // reference model state
  rename_pkg::preg_t         rat [`RN_ARCH_REGS];
  rename_pkg::preg_t         fl_q [$];
  rename_pkg::preg_t         retire_q [$];
  rename_pkg::ren_group_t    exp_q [$];
  int                        row_q [$];

  logic [15:0] lfsr = 16'd51563;
  int          err_cnt  = 0;
  int          last_err = 0;
  int          test_cnt = 0;

  rename_stage uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .dec_valid_i  (dec_valid_i),
    .dec_group_i  (dec_group_i),
    .plv_i        (plv_i),
    .dec_ready_o  (dec_ready_o),
    .ren_valid_o  (ren_valid_o),
    .ren_group_o  (ren_group_o),
    .ren_ready_i  (ren_ready_i),
    .free_valid_i (free_valid_i),
    .free_preg_i  (free_preg_i)
  );

  always #50 clk = ~clk;

  // ========================================
  // helpers
  // ========================================
  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int k = 0; k < n; k++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      v = (v << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic compare(input string what, input logic [127:0] exp, input logic [127:0] act);
    if (exp !== act) begin
      err_cnt++;
      $display("Error: %s expected %0h actual %0h", what, exp, act);
    end
  endtask

  function automatic rename_pkg::dec_lane_t make_lane(int cls, int ine, int flt,
                                                      int s0, int s1, int d);
    rename_pkg::dec_lane_t l;
    l.valid        = 1'b1;
    l.iclass       = rename_pkg::instr_class_e'(3'(cls));
    l.invalid_inst = (ine != 0);
    l.fault_valid  = (flt != 0);
    l.fault_ecode  = 6'h05;
    l.src0         = rename_pkg::areg_t'(s0);
    l.src1         = rename_pkg::areg_t'(s1);
    l.dest         = rename_pkg::areg_t'(d);
    return l;
  endfunction

  task automatic set_row(int r, string nm, rename_pkg::dec_lane_t l0,
                         rename_pkg::dec_lane_t l1, int plv, int nfree, int hold);
    row_name[r]  = nm;
    row_grp[r]   = {l1, l0};
    row_plv[r]   = rename_pkg::plv_t'(plv);
    row_nfree[r] = nfree;
    row_hold[r]  = hold;
  endtask

  // exception result per lane as {excp_valid, ecode}, highest priority first
  function automatic logic [6:0] screen_lane(rename_pkg::dec_lane_t l, rename_pkg::plv_t plv);
    if (!l.valid) return 7'h00;
    if (l.fault_valid) return {1'b1, l.fault_ecode};
    if (l.invalid_inst) return {1'b1, `RN_ECODE_INE};
    if (l.iclass == rename_pkg::CLASS_PRIV && plv == `RN_PLV_USER) return {1'b1, `RN_ECODE_IPE};
    if (l.iclass == rename_pkg::CLASS_SYSCALL) return {1'b1, `RN_ECODE_SYS};
    if (l.iclass == rename_pkg::CLASS_BRK) return {1'b1, `RN_ECODE_BRK};
    return 7'h00;
  endfunction

  function automatic int count_need(int r);
    int         n;
    logic [6:0] s;
    n = 0;
    for (int i = 0; i < `RN_LANES; i++) begin
      s = screen_lane(row_grp[r][i], row_plv[r]);
      if (row_grp[r][i].valid && !s[6] && row_grp[r][i].dest != '0) begin
        n++;
      end
    end
    return n;
  endfunction

  // walks lanes in order, so lane 1 sees lane 0's new mapping
  task automatic predict(input int r);
    rename_pkg::ren_group_t g;
    rename_pkg::dec_lane_t  l;
    logic [6:0]             s;
    for (int i = 0; i < `RN_LANES; i++) begin
      l = row_grp[r][i];
      s = screen_lane(l, row_plv[r]);
      g[i].valid      = l.valid;
      g[i].excp_valid = s[6];
      g[i].ecode      = s[5:0];
      g[i].dest_valid = l.valid && !s[6] && (l.dest != '0);
      g[i].arch_dest  = l.dest;
      g[i].psrc0      = rat[l.src0];
      g[i].psrc1      = rat[l.src1];
      g[i].pdest      = '0;
      g[i].old_pdest  = '0;
      if (g[i].dest_valid) begin
        g[i].old_pdest = rat[l.dest];
        g[i].pdest     = (fl_q.size() > 0) ? fl_q.pop_front() : '0;
        rat[l.dest]    = g[i].pdest;
        retire_q.push_back(g[i].old_pdest);
      end
    end
    exp_q.push_back(g);
    row_q.push_back(r);
  endtask

  task automatic present_row(input int r);
    logic [`RN_LANES-1:0]    fv;
    rename_pkg::preg_lanes_t fp;
    fv = '0;
    fp = '0;
    for (int k = 0; k < row_nfree[r] && retire_q.size() > 0; k++) begin
      fv[k] = 1'b1;
      fp[k] = retire_q.pop_front();
    end
    dec_valid_i  <= 1'b1;
    dec_group_i  <= row_grp[r];
    plv_i        <= row_plv[r];
    free_valid_i <= fv;
    free_preg_i  <= fp;
  endtask

  task automatic finish_test();
    rename_pkg::ren_group_t g;
    int r;
    r = row_q.pop_front();
    g = exp_q.pop_front();
    compare({row_name[r], " group"}, 128'(g), 128'(ren_group_o));
    $display("test %0d %s: %s", r, row_name[r], (err_cnt == last_err) ? "ok" : "mismatch");
    last_err = err_cnt;
    test_cnt++;
  endtask

  // ========================================
  // table
  // ========================================
  task automatic build_table();
    rename_pkg::dec_lane_t l;
    int c;
    int a;
    int b;
    int d;
    int e;
    int v;
    set_row(0, "identity", make_lane(0, 0, 0, 2, 3, 1), make_lane(0, 0, 0, 5, 6, 4), 0, 0, 0);
    set_row(1, "bypass", make_lane(0, 0, 0, 1, 2, 7), make_lane(0, 0, 0, 7, 7, 7), 0, 0, 2);
    set_row(2, "fault", make_lane(3, 1, 1, 1, 2, 3), make_lane(0, 0, 0, 3, 4, 8), 3, 0, 0);
    set_row(3, "ine_ipe", make_lane(4, 1, 0, 1, 1, 9), make_lane(3, 0, 0, 2, 2, 10), 3, 0, 1);
    set_row(4, "sys_brk", make_lane(4, 0, 0, 3, 4, 11), make_lane(5, 0, 0, 5, 6, 12), 0, 0, 3);
    l = make_lane(0, 0, 0, 1, 2, 11);
    l.valid = 1'b0;
    set_row(5, "priv_kernel", make_lane(3, 0, 0, 8, 9, 10), l, 0, 0, 0);
    // drain the free list down to one entry without frees
    for (int r = 6; r < 19; r++) begin
      set_row(r, "drain", make_lane(1, 0, 0, r - 5, r - 4, r - 5),
              make_lane(0, 0, 0, r, r - 5, (r == 18) ? 0 : r + 10), 0, 0, 0);
    end
    set_row(19, "refill", make_lane(0, 0, 0, 1, 16, 20), make_lane(0, 0, 0, 20, 13, 21),
            0, 2, 0);
    for (int r = 20; r < NROWS; r++) begin
      set_row(r, "random", make_lane(0, 0, 0, 0, 0, 0), make_lane(0, 0, 0, 0, 0, 0), 0, 2, 0);
      for (int i = 0; i < `RN_LANES; i++) begin
        take_bits(3, c);
        take_bits(5, a);
        take_bits(5, b);
        take_bits(5, d);
        take_bits(4, e);
        take_bits(3, v);
        row_grp[r][i] = make_lane(c % 6, int'(e == 0), int'(e == 1), a, b, d);
        row_grp[r][i].valid = (v != 0);
      end
      take_bits(2, c);
      row_plv[r] = rename_pkg::plv_t'(c);
      take_bits(2, row_hold[r]);
    end
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial begin
    rename_pkg::ren_group_t held;
    string out_name;
    logic stalled;
    logic exp_ready;
    logic accepted;
    int   r;
    int   idle;
    int   hold_cnt;
    int   avail;
    rst_n        <= 1'b0;
    dec_valid_i  <= 1'b0;
    dec_group_i  <= '0;
    plv_i        <= '0;
    ren_ready_i  <= 1'b1;
    free_valid_i <= '0;
    free_preg_i  <= '0;
    r = 0;
    idle = 0;
    hold_cnt = 0;
    stalled = 1'b0;
    held = '0;
    build_table();
    for (int i = 0; i < `RN_ARCH_REGS; i++) rat[i] = rename_pkg::preg_t'(i);
    for (int i = `RN_ARCH_REGS; i < `RN_PHYS_REGS; i++) fl_q.push_back(rename_pkg::preg_t'(i));
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    present_row(0);
    while (test_cnt < NROWS && idle < STALL_LIMIT) begin
      @(negedge clk);
      idle++;
      // output side
      if (ren_valid_o && stalled) begin
        out_name = "unexpected";
        if (row_q.size() > 0) begin
          out_name = row_name[row_q[0]];
        end
        compare({out_name, " held output"}, 128'(held), 128'(ren_group_o));
      end
      if (ren_valid_o && ren_ready_i) begin
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("output handshake with no accepted group outstanding");
        end else begin
          finish_test();
        end
        idle = 0;
      end
      stalled = ren_valid_o && !ren_ready_i;
      held = ren_group_o;
      if (stalled && hold_cnt > 0) hold_cnt--;
      // input side
      accepted = 1'b0;
      if (dec_valid_i) begin
        avail = (fl_q.size() > 1) ? 2 : fl_q.size();
        exp_ready = (!ren_valid_o || ren_ready_i) && (avail >= count_need(r));
        compare({row_name[r], " ready"}, 128'(exp_ready), 128'(dec_ready_o));
        accepted = dec_ready_o;
        if (accepted) begin
          predict(r);
          hold_cnt = row_hold[r];
          idle = 0;
        end
      end
      // frees land on the coming edge, behind any pops
      for (int k = 0; k < `RN_LANES; k++) begin
        if (free_valid_i[k]) fl_q.push_back(free_preg_i[k]);
      end
      @(posedge clk);
      ren_ready_i  <= (hold_cnt == 0);
      free_valid_i <= '0;
      if (accepted) begin
        r++;
        if (r < NROWS) present_row(r);
        else dec_valid_i <= 1'b0;
      end
    end
    if (idle >= STALL_LIMIT) begin
      err_cnt++;
      $display("timeout after %0d cycles without a handshake at row %0d", STALL_LIMIT, r);
    end
    $display("tests %0d of %0d, errors %0d", test_cnt, NROWS, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+hdl
hdl/rename_pkg.sv
hdl/decode_screen.sv
hdl/free_list.sv
hdl/rename_table.sv
hdl/rename_merge.sv
hdl/rename_stage.sv
verif/rename_props.sv
verif/rename_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rename_tb
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps

SRCS := $(filter-out +incdir+%,$(shell cat sources.f)) $(wildcard hdl/*.svh)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) sources.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f sources.f

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "simulation ended early, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)
